/* hw/i2c_init_pkg.sv */
// types shared by the init sequencer blocks; the table word is 9 bits and read in two views
package i2c_init_pkg;

    // data view, top bit set means write this byte
    typedef struct packed {
        logic       flag;
        logic [7:0] value;
    } data_view_t;

    // control view, opcode plus a 7-bit field
    // opcode 01 carries a device address, 00 is a whole-word command
    typedef struct packed {
        logic [1:0] op;
        logic [6:0] field;
    } ctrl_view_t;

    // one table entry, decoded either way
    typedef union packed {
        data_view_t data;
        ctrl_view_t ctrl;
    } table_word_u;

    // command to the external I2C master
    typedef struct packed {
        logic [6:0] address;
        logic       start;
        logic       write;
        logic       stop;
    } i2c_cmd_t;

    // table patch request, flags are single-cycle
    typedef struct packed {
        logic       host_wr;
        logic [6:0] dev_addr;
        logic [7:0] reg_byte;
        logic [7:0] data_byte;
        logic       filter_wr;
        logic [6:0] filter_val;
    } host_req_t;

endpackage

/* hw/i2c_init_sequencer.sv */
// walks the table one word per cycle at most; rd_index is combinational, cmd and data outputs are registered
`timescale 1ns/100ps
`include "i2c_init_consts.svh"

module i2c_init_sequencer (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          start,
    input  logic [`I2C_INIT_ADDR_W-1:0]   start_entry,
    input  i2c_init_pkg::table_word_u     rd_word,
    input  logic                          cmd_ready,
    input  logic                          data_out_ready,
    output logic                          idle,
    output logic [`I2C_INIT_ADDR_W-1:0]   rd_index,
    output i2c_init_pkg::i2c_cmd_t        cmd,
    output logic                          cmd_valid,
    output logic [7:0]                    data_out,
    output logic                          data_out_valid,
    output logic                          busy
);

    typedef enum logic [1:0] {
        state_idle,
        state_fetch,
        state_run
    } state_t;

    state_t                        state;
    state_t                        state_next;
    logic [`I2C_INIT_ADDR_W-1:0]   index;
    logic [`I2C_INIT_ADDR_W-1:0]   index_next;
    i2c_init_pkg::i2c_cmd_t        cmd_next;
    logic                          cmd_valid_next;
    logic [7:0]                    data_out_next;
    logic                          data_out_valid_next;

    // free only once the last stop has gone out
    assign idle = (state == state_idle) & ~cmd_valid & ~data_out_valid;

    // table reads the next index, so the word is ready when the state gets there
    assign rd_index = index_next;

    always_comb begin
        state_next = state;
        index_next = index;
        data_out_next = data_out;
        // pending start and flags clear once the master takes the command
        cmd_next = cmd;
        if (cmd_valid && cmd_ready) begin
            cmd_next.start = 1'b0;
            cmd_next.write = 1'b0;
            cmd_next.stop = 1'b0;
        end
        cmd_valid_next = cmd_valid & ~cmd_ready;
        data_out_valid_next = data_out_valid & ~data_out_ready;

        case (state)
            state_idle: begin
                if (start) begin
                    index_next = start_entry;
                    state_next = state_fetch;
                end
            end
            state_fetch: begin
                // re-read after the patch edge
                state_next = state_run;
            end
            state_run: begin
                // hold the entry while either channel is still full
                if (!cmd_valid && !data_out_valid) begin
                    if (rd_word.data.flag) begin
                        // data byte, start bit carries over from an address word
                        cmd_next.write = 1'b1;
                        cmd_next.stop = 1'b0;
                        cmd_valid_next = 1'b1;
                        data_out_next = rd_word.data.value;
                        data_out_valid_next = 1'b1;
                        index_next = index + 1'b1;
                    end else if (rd_word.ctrl.op == `I2C_INIT_OP_ADDR) begin
                        // address only, nothing sent yet
                        cmd_next.address = rd_word.ctrl.field;
                        cmd_next.start = 1'b1;
                        index_next = index + 1'b1;
                    end else if (rd_word == `I2C_INIT_WORD_STOP) begin
                        cmd_next.start = 1'b0;
                        cmd_next.write = 1'b0;
                        cmd_next.stop = 1'b1;
                        cmd_valid_next = 1'b1;
                        index_next = index + 1'b1;
                    end else if (rd_word == `I2C_INIT_WORD_END) begin
                        // end of list also closes the bus
                        cmd_next.start = 1'b0;
                        cmd_next.write = 1'b0;
                        cmd_next.stop = 1'b1;
                        cmd_valid_next = 1'b1;
                        state_next = state_idle;
                    end else begin
                        // unknown control word, skip
                        index_next = index + 1'b1;
                    end
                end
            end
            default: begin
                state_next = state_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= state_idle;
            index <= '0;
            cmd.start <= 1'b0;
            cmd_valid <= 1'b0;
            data_out_valid <= 1'b0;
            busy <= 1'b0;
        end else begin
            state <= state_next;
            index <= index_next;
            cmd.start <= cmd_next.start;
            cmd_valid <= cmd_valid_next;
            data_out_valid <= data_out_valid_next;
            // lags the state by one cycle
            busy <= (state != state_idle);
        end
        cmd.address <= cmd_next.address;
        cmd.write <= cmd_next.write;
        cmd.stop <= cmd_next.stop;
        data_out <= data_out_next;
    end

endmodule

/* hw/i2c_init_table.sv */
// 12-word command table, defaults restored by reset, out-of-range reads return end of list
`timescale 1ns/100ps
`include "i2c_init_consts.svh"

module i2c_init_table (
    input  logic                          clk,
    input  logic                          rst,
    input  i2c_init_pkg::host_req_t       host_req,
    input  logic [`I2C_INIT_ADDR_W-1:0]   rd_index,
    output i2c_init_pkg::table_word_u     rd_word
);

    i2c_init_pkg::table_word_u mem [`I2C_INIT_TABLE_LEN];

    // write side, defaults and patches
    always_ff @(posedge clk) begin
        if (rst) begin
            mem[0] <= `I2C_INIT_DEFAULT_0;
            mem[1] <= `I2C_INIT_DEFAULT_1;
            mem[2] <= `I2C_INIT_DEFAULT_2;
            mem[3] <= `I2C_INIT_DEFAULT_3;
            mem[4] <= `I2C_INIT_DEFAULT_4;
            mem[5] <= `I2C_INIT_DEFAULT_5;
            mem[6] <= `I2C_INIT_DEFAULT_6;
            mem[7] <= `I2C_INIT_DEFAULT_7;
            mem[8] <= `I2C_INIT_DEFAULT_8;
            mem[9] <= `I2C_INIT_DEFAULT_9;
            mem[10] <= `I2C_INIT_DEFAULT_10;
            mem[11] <= `I2C_INIT_DEFAULT_11;
        end else begin
            // host word: device address, register byte, data byte
            if (host_req.host_wr) begin
                mem[`I2C_INIT_ENTRY_HOST].ctrl <= '{
                    op: `I2C_INIT_OP_ADDR,
                    field: host_req.dev_addr
                };
                mem[`I2C_INIT_ENTRY_HOST + 1].data <= '{
                    flag: 1'b1,
                    value: host_req.reg_byte
                };
                mem[`I2C_INIT_ENTRY_HOST + 2].data <= '{
                    flag: 1'b1,
                    value: host_req.data_byte
                };
            end
            // filter value lands as a data byte, msb forced low
            if (host_req.filter_wr) begin
                mem[`I2C_INIT_ENTRY_FILTER].data <= '{
                    flag: 1'b1,
                    value: {1'b0, host_req.filter_val}
                };
            end
        end
    end

    // registered read port
    // word seen one cycle after the index
    always_ff @(posedge clk) begin
        if (rd_index < `I2C_INIT_TABLE_LEN) begin
            rd_word <= mem[rd_index];
        end else begin
            rd_word <= `I2C_INIT_WORD_END;
        end
    end

endmodule

/* hw/i2c_init_top.sv */
// I2C bring-up sequencer top; needs an external I2C master on the cmd and data channels
`timescale 1ns/100ps
`include "i2c_init_consts.svh"

module i2c_init_top (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      init_start,
    input  logic                      write,
    input  logic [31:0]               data,
    input  logic [6:0]                filter_select,
    output i2c_init_pkg::i2c_cmd_t    cmd,
    output logic                      cmd_valid,
    input  logic                      cmd_ready,
    output logic [7:0]                data_out,
    output logic                      data_out_valid,
    input  logic                      data_out_ready,
    output logic                      busy
);

    i2c_init_pkg::host_req_t       host_req;
    i2c_init_pkg::table_word_u     rd_word;
    logic                          start;
    logic                          idle;
    logic [`I2C_INIT_ADDR_W-1:0]   start_entry;
    logic [`I2C_INIT_ADDR_W-1:0]   rd_index;

    // start sources and patch requests
    i2c_init_trigger i_i2c_init_trigger (
        .clk           (clk),
        .rst           (rst),
        .init_start    (init_start),
        .write         (write),
        .data          (data),
        .filter_select (filter_select),
        .idle          (idle),
        .start         (start),
        .start_entry   (start_entry),
        .host_req      (host_req)
    );

    // command words
    i2c_init_table i_i2c_init_table (
        .clk      (clk),
        .rst      (rst),
        .host_req (host_req),
        .rd_index (rd_index),
        .rd_word  (rd_word)
    );

    i2c_init_sequencer i_i2c_init_sequencer (
        .clk            (clk),
        .rst            (rst),
        .start          (start),
        .start_entry    (start_entry),
        .rd_word        (rd_word),
        .cmd_ready      (cmd_ready),
        .data_out_ready (data_out_ready),
        .idle           (idle),
        .rd_index       (rd_index),
        .cmd            (cmd),
        .cmd_valid      (cmd_valid),
        .data_out       (data_out),
        .data_out_valid (data_out_valid),
        .busy           (busy)
    );

endmodule

/* hw/i2c_init_trigger.sv */
// filter_select is async and sampled through two flops; data[31:23] are ignored; starts need idle
`timescale 1ns/100ps
`include "i2c_init_consts.svh"

module i2c_init_trigger (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          init_start,
    input  logic                          write,
    input  logic [31:0]                   data,
    input  logic [6:0]                    filter_select,
    input  logic                          idle,
    output logic                          start,
    output logic [`I2C_INIT_ADDR_W-1:0]   start_entry,
    output i2c_init_pkg::host_req_t       host_req
);

    logic [6:0] filter_meta;
    logic [6:0] filter_sync;
    logic [6:0] filter_last;
    logic       filter_change;
    logic       any_src;
    logic       hold;
    logic       accept;

    // sync chain plus last value, tracks the pin during reset
    // so no change shows up at release
    always_ff @(posedge clk) begin
        filter_meta <= filter_select;
        filter_sync <= filter_meta;
        filter_last <= filter_sync;
    end

    // one-cycle flag per settled change
    assign filter_change = (filter_sync != filter_last);

    assign any_src = write | filter_change | init_start;
    // only when sequencer free and all sources dropped since last start
    assign accept = idle & ~hold & any_src;

    always_ff @(posedge clk) begin
        if (rst) begin
            start <= 1'b0;
            hold <= 1'b0;
            host_req.host_wr <= 1'b0;
            host_req.filter_wr <= 1'b0;
        end else begin
            start <= accept;
            // re-arm once nothing is asserted
            if (accept) begin
                hold <= 1'b1;
            end else if (!any_src) begin
                hold <= 1'b0;
            end
            // host write wins over filter change, init patches nothing
            host_req.host_wr <= accept & write;
            host_req.filter_wr <= accept & ~write & filter_change;
        end
        // payload, only meaningful alongside the flags
        start_entry <= write ? `I2C_INIT_ENTRY_HOST : `I2C_INIT_ENTRY_INIT;
        host_req.dev_addr <= data[22:16];
        host_req.reg_byte <= data[15:8];
        host_req.data_byte <= data[7:0];
        host_req.filter_val <= filter_sync;
    end

endmodule

/* include/i2c_init_consts.svh */
// table is fixed at 12 entries with a 4-bit index, words are 9 bits, only single-device commands
`ifndef I2C_INIT_CONSTS_SVH
`define I2C_INIT_CONSTS_SVH

// table geometry
`define I2C_INIT_TABLE_LEN 12
`define I2C_INIT_ADDR_W 4

// first entry of each kind of run
`define I2C_INIT_ENTRY_HOST 4'd0
`define I2C_INIT_ENTRY_INIT 4'd4
// entry rewritten by a filter select change
`define I2C_INIT_ENTRY_FILTER 4'd10

// control view opcode for start write to address
`define I2C_INIT_OP_ADDR 2'b01
// whole-word control commands
`define I2C_INIT_WORD_STOP 9'h041
`define I2C_INIT_WORD_END 9'h000

// default contents, first block is the host-patchable device setup
`define I2C_INIT_DEFAULT_0 {2'b01, 7'h28}
`define I2C_INIT_DEFAULT_1 {1'b1, 8'h00}
`define I2C_INIT_DEFAULT_2 {1'b1, 8'hfe}
`define I2C_INIT_DEFAULT_3 `I2C_INIT_WORD_STOP
// port direction setup
`define I2C_INIT_DEFAULT_4 {2'b01, 7'h20}
`define I2C_INIT_DEFAULT_5 {1'b1, 8'h00}
`define I2C_INIT_DEFAULT_6 {1'b1, 8'h00}
`define I2C_INIT_DEFAULT_7 `I2C_INIT_WORD_STOP
// filter data, entry 10 follows filter_select
`define I2C_INIT_DEFAULT_8 {2'b01, 7'h20}
`define I2C_INIT_DEFAULT_9 {1'b1, 8'h0a}
`define I2C_INIT_DEFAULT_10 {1'b1, 8'h20}
`define I2C_INIT_DEFAULT_11 `I2C_INIT_WORD_END

`endif

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the I2C init testbench with Verilator, from the project root

cd "$(dirname "$0")" || exit 1

log_file=sim.log

verilator --binary --timing -Wno-fatal --top-module tb_i2c_init \
    -f vlog.f -Mdir obj_dir -o sim_tb
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/sim_tb > "$log_file" 2>&1
status=$?
cat "$log_file"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q '\*\*\* TEST FAILED \*\*\*' "$log_file"; then
    echo "failure reported, see $log_file"
    exit 1
fi

echo "no failure reported in $log_file"
exit 0

/* verification/i2c_init_patterns.txt */
# S kind value mode : kind init, host or filter; value in hex; mode 0 ready high, 1 random, 2 both
# T addr start write stop data : one command in order; data byte is sent only when write is 1
S init 0 2
T 20 1 1 0 00
T 20 0 1 0 00
T 20 0 0 1 00
T 20 1 1 0 0a
T 20 0 1 0 20
T 20 0 0 1 00
S host 00500411 2
T 50 1 1 0 04
T 50 0 1 0 11
T 50 0 0 1 00
T 20 1 1 0 00
T 20 0 1 0 00
T 20 0 0 1 00
T 20 1 1 0 0a
T 20 0 1 0 20
T 20 0 0 1 00
S filter 33 2
T 20 1 1 0 00
T 20 0 1 0 00
T 20 0 0 1 00
T 20 1 1 0 0a
T 20 0 1 0 33
T 20 0 0 1 00

/* verification/tb_i2c_init.sv */
// run from the project root so the pattern file is found; every test starts from a fresh reset
`timescale 1ns/100ps

module tb_i2c_init;

    logic                      clk;
    logic                      rst;
    logic                      init_start;
    logic                      write;
    logic [31:0]               data;
    logic [6:0]                filter_select;
    i2c_init_pkg::i2c_cmd_t    cmd;
    logic                      cmd_valid;
    logic                      cmd_ready;
    logic [7:0]                data_out;
    logic                      data_out_valid;
    logic                      data_out_ready;
    logic                      busy;

    // scenarios from the pattern file
    logic [63:0]               sc_kind[$];
    logic [31:0]               sc_value[$];
    int                        sc_mode[$];
    int                        sc_first[$];
    int                        sc_count[$];
    // transactions of all scenarios in one flat list
    i2c_init_pkg::i2c_cmd_t    tr_cmd[$];
    logic [7:0]                tr_data[$];
    // what the running test still expects
    i2c_init_pkg::i2c_cmd_t    exp_cmd_q[$];
    logic [7:0]                exp_data_q[$];
    i2c_init_pkg::i2c_cmd_t    mon_cmd;
    logic [7:0]                mon_byte;

    logic                      bp_on;
    int                        errors;
    int                        checks;
    int                        tests_run;
    int                        tests_failed;
    int                        cycle_count;
    int                        cycle_limit;
    int                        load_ok;
    int                        i;

    i2c_init_top i_i2c_init_top (
        .clk            (clk),
        .rst            (rst),
        .init_start     (init_start),
        .write          (write),
        .data           (data),
        .filter_select  (filter_select),
        .cmd            (cmd),
        .cmd_valid      (cmd_valid),
        .cmd_ready      (cmd_ready),
        .data_out       (data_out),
        .data_out_valid (data_out_valid),
        .data_out_ready (data_out_ready),
        .busy           (busy)
    );

    // 40 ns period
    always #20 clk = ~clk;

    // hard stop at the cycle limit
    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: DUT still running after %0d cycles", cycle_count);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    // master model seeds its own generator once
    // ready is either always high or a coin flip per cycle
    initial begin
        void'($urandom(34));
        forever begin
            @(posedge clk);
            #2;
            if (bp_on) begin
                cmd_ready = (($urandom() & 1) == 1);
                data_out_ready = (($urandom() & 1) == 1);
            end else begin
                cmd_ready = 1'b1;
                data_out_ready = 1'b1;
            end
        end
    end

    // transfers sampled mid-cycle where valid and ready are settled
    always @(negedge clk) begin
        if (!rst && cmd_valid && cmd_ready) begin
            if (exp_cmd_q.size() == 0) begin
                errors = errors + 1;
                $display("extra command transfer at %t, nothing more was expected", $realtime);
            end else begin
                mon_cmd = exp_cmd_q.pop_front();
                compare_cmd(mon_cmd, cmd);
            end
        end
        if (!rst && data_out_valid && data_out_ready) begin
            if (exp_data_q.size() == 0) begin
                errors = errors + 1;
                $display("extra data transfer at %t, nothing more was expected", $realtime);
            end else begin
                mon_byte = exp_data_q.pop_front();
                compare_byte(mon_byte, data_out);
            end
        end
    end

    task automatic compare_cmd(input i2c_init_pkg::i2c_cmd_t exp,
                               input i2c_init_pkg::i2c_cmd_t act);
        checks = checks + 1;
        if (act !== exp) begin
            errors = errors + 1;
            $display("CHECK FAILED at %t cmd: expected %h s%b w%b p%b, actual %h s%b w%b p%b",
                     $realtime, exp.address, exp.start, exp.write, exp.stop,
                     act.address, act.start, act.write, act.stop);
        end
    endtask

    task automatic compare_byte(input logic [7:0] exp, input logic [7:0] act);
        checks = checks + 1;
        if (act !== exp) begin
            errors = errors + 1;
            $display("CHECK FAILED at %t data_out: expected %h, actual %h", $realtime, exp, act);
        end
    endtask

    task automatic compare_busy(input logic exp, input logic act);
        checks = checks + 1;
        if (act !== exp) begin
            errors = errors + 1;
            $display("CHECK FAILED at %t busy: expected %b, actual %b", $realtime, exp, act);
        end
    endtask

    task automatic compare_valid(input string name, input logic exp, input logic act);
        checks = checks + 1;
        if (act !== exp) begin
            errors = errors + 1;
            $display("CHECK FAILED at %t %s: expected %b, actual %b", $realtime, name, exp, act);
        end
    endtask

    task automatic load_patterns(output int ok);
        int                     fd;
        int                     n;
        int                     bad;
        int                     mode;
        int                     st;
        int                     wr;
        int                     sp;
        logic [63:0]            tag;
        logic [63:0]            kind;
        logic [1023:0]          rest;
        logic [31:0]            value;
        logic [6:0]             addr;
        logic [7:0]             db;
        i2c_init_pkg::i2c_cmd_t c;
        ok = 0;
        bad = 0;
        fd = $fopen("verification/i2c_init_patterns.txt", "r");
        if (fd == 0) begin
            $display("cannot open verification/i2c_init_patterns.txt");
        end else begin
            while ($fscanf(fd, "%s", tag) == 1) begin
                if (tag == "S") begin
                    n = $fscanf(fd, "%s %h %d", kind, value, mode);
                    if (n != 3) begin
                        bad = bad + 1;
                    end
                    sc_kind.push_back(kind);
                    sc_value.push_back(value);
                    sc_mode.push_back(mode);
                    sc_first.push_back(tr_cmd.size());
                    sc_count.push_back(0);
                end else if (tag == "T" && sc_count.size() > 0) begin
                    n = $fscanf(fd, "%h %d %d %d %h", addr, st, wr, sp, db);
                    if (n != 5) begin
                        bad = bad + 1;
                    end
                    c.address = addr;
                    c.start = st[0];
                    c.write = wr[0];
                    c.stop = sp[0];
                    tr_cmd.push_back(c);
                    tr_data.push_back(db);
                    sc_count[sc_count.size() - 1] = sc_count[sc_count.size() - 1] + 1;
                end else begin
                    // comment line skipped to its end
                    n = $fgets(rest, fd);
                end
            end
            $fclose(fd);
            if (bad != 0) begin
                $display("pattern file has %0d lines that do not parse", bad);
            end
            ok = (sc_kind.size() > 0 && bad == 0) ? 1 : 0;
        end
    endtask

    // all inputs back to rest with filter_select cleared so a later change is seen
    task automatic apply_reset(input logic bp);
        @(posedge clk);
        #2;
        bp_on = bp;
        rst = 1'b1;
        init_start = 1'b0;
        write = 1'b0;
        data = '0;
        filter_select = '0;
        repeat (8) @(posedge clk);
        #2;
        rst = 1'b0;
    endtask

    // nothing may run here
    // returns on a drive slot
    task automatic check_quiet(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            compare_busy(1'b0, busy);
            compare_valid("cmd_valid", 1'b0, cmd_valid);
            compare_valid("data_out_valid", 1'b0, data_out_valid);
        end
        @(posedge clk);
        #2;
    endtask

    task automatic run_test(input int idx, input logic bp);
        int          err_before;
        int          j;
        logic [31:0] value;
        err_before = errors;
        value = sc_value[idx];
        apply_reset(bp);
        exp_cmd_q.delete();
        exp_data_q.delete();
        for (j = sc_first[idx]; j < sc_first[idx] + sc_count[idx]; j++) begin
            exp_cmd_q.push_back(tr_cmd[j]);
            if (tr_cmd[j].write) begin
                exp_data_q.push_back(tr_data[j]);
            end
        end
        check_quiet(4);
        if (sc_kind[idx] == "host") begin
            write = 1'b1;
            data = value;
            @(posedge clk);
            #2;
            write = 1'b0;
        end else if (sc_kind[idx] == "filter") begin
            filter_select = value[6:0];
        end else begin
            // held through the run and after it
            init_start = 1'b1;
        end
        while (busy !== 1'b1) @(negedge clk);
        while (busy !== 1'b0 || cmd_valid !== 1'b0 || data_out_valid !== 1'b0) @(negedge clk);
        // a held start must not bring a second run
        check_quiet(10);
        init_start = 1'b0;
        if (exp_cmd_q.size() != 0 || exp_data_q.size() != 0) begin
            errors = errors + 1;
            $display("run ended with %0d commands and %0d data bytes never transferred",
                     exp_cmd_q.size(), exp_data_q.size());
        end
        tests_run = tests_run + 1;
        if (errors == err_before) begin
            $display("test %0d %0s backpressure %0d: ok", tests_run, sc_kind[idx], bp);
        end else begin
            tests_failed = tests_failed + 1;
            $display("test %0d %0s backpressure %0d: %0d errors", tests_run, sc_kind[idx], bp,
                     errors - err_before);
        end
    endtask

    initial begin
        $timeformat(-9, 1, " ns", 0);
        clk = 1'b0;
        rst = 1'b1;
        init_start = 1'b0;
        write = 1'b0;
        data = '0;
        filter_select = '0;
        cmd_ready = 1'b0;
        data_out_ready = 1'b0;
        bp_on = 1'b0;
        errors = 0;
        checks = 0;
        tests_run = 0;
        tests_failed = 0;
        cycle_count = 0;
        cycle_limit = 200;
        load_patterns(load_ok);
        if (load_ok != 0) begin
            // transactions over all runs where a mode 2 scenario runs twice
            cycle_limit = 0;
            for (i = 0; i < sc_kind.size(); i++) begin
                cycle_limit = cycle_limit + sc_count[i] * ((sc_mode[i] == 2) ? 2 : 1);
            end
            cycle_limit = cycle_limit * 20 + 200;
            for (i = 0; i < sc_kind.size(); i++) begin
                if (sc_mode[i] != 1) begin
                    run_test(i, 1'b0);
                end
                if (sc_mode[i] != 0) begin
                    run_test(i, 1'b1);
                end
            end
        end else begin
            errors = errors + 1;
            $display("pattern file gave no usable scenarios to run");
        end
        $display("tests %0d, failed %0d, checks %0d, errors %0d", tests_run, tests_failed,
                 checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* vlog.f */
+incdir+include
hw/i2c_init_pkg.sv
hw/i2c_init_trigger.sv
hw/i2c_init_table.sv
hw/i2c_init_sequencer.sv
hw/i2c_init_top.sv
verification/tb_i2c_init.sv
